// File: vlog.f
rtl/skdecode_pkg.sv
rtl/skdecode_rd_buffer.sv
rtl/skdecode_s1s2_unpack.sv
rtl/skdecode_t0_unpack.sv
rtl/skdecode_ctrl.sv
rtl/skdecode_top.sv
verif/skdecode_tb.sv

// File: Makefile
.PHONY: sim clean

sim:
	verilator --binary --timing -f vlog.f --top-module skdecode_tb -o skdecode_sim
	./obj_dir/skdecode_sim > sim.log 2>&1
	cat sim.log
	@if grep -q "CHECKS FAILED" sim.log; then \
		echo "simulation reported failures"; \
		exit 1; \
	fi

clean:
	rm -rf obj_dir sim.log

// File: verif/skdecode_tb.sv
// testbench for the secret-key decoder, models both memories and checks every decoded coefficient
module skdecode_tb
    import skdecode_pkg::*;
();

    // ==============================
    // run sizing and watchdog
    // ==============================
    localparam int N_RUNS     = 5;
    localparam int S1S2_ADDRS = 2 * S1S2_WR_CYCLES;
    localparam int RUN_CYCLES = S1S2_WORDS + T0_WORDS / 2 + S1S2_WR_CYCLES + T0_WR_CYCLES;
    localparam int WATCHDOG_CYCLES = 4 * N_RUNS * RUN_CYCLES;

    logic            clk;
    logic            reset_n;
    logic            zeroize_i;
    logic            skdecode_enable_i;
    addr_t           src_base;
    addr_t           dest_base;
    logic [1:0]      rd_en;
    addr_t [1:0]     rd_addr;
    key_word_t [1:0] rd_data = '0;
    logic [1:0]      rd_valid = '0;
    logic            mem_a_wr_en_o;
    addr_t           mem_a_wr_addr_o;
    coeff_t [3:0]    mem_a_wr_data_o;
    logic            mem_b_wr_en_o;
    addr_t           mem_b_wr_addr_o;
    coeff_t [3:0]    mem_b_wr_data_o;
    logic            s1_done_o;
    logic            s2_done_o;
    logic            t0_done_o;
    logic            skdecode_done_o;
    logic            error_o;

    key_word_t              key_mem [0:(1<<ADDR_W)-1];
    logic [4*COEFF_W-1:0]   dest_mem [0:(1<<ADDR_W)-1];
    logic [31:0]            rng = 32'd55;
    int                     cur_src;
    int                     cur_dst;
    logic                   exp_err;
    int                     main_errors;
    int                     cmp_errors;
    int                     coeff_checks;
    int                     runs_done;
    int                     a_writes;
    int                     rd_a_reads;
    int                     s1_pulses;
    int                     s2_pulses;

    skdecode_top u_dut (
        .clk                    (clk),
        .reset_n                (reset_n),
        .zeroize_i              (zeroize_i),
        .skdecode_enable_i      (skdecode_enable_i),
        .keymem_src_base_addr_i (src_base),
        .dest_base_addr_i       (dest_base),
        .keymem_rd_en_o         (rd_en),
        .keymem_rd_addr_o       (rd_addr),
        .keymem_rd_data_i       (rd_data),
        .keymem_rd_valid_i      (rd_valid),
        .mem_a_wr_en_o          (mem_a_wr_en_o),
        .mem_a_wr_addr_o        (mem_a_wr_addr_o),
        .mem_a_wr_data_o        (mem_a_wr_data_o),
        .mem_b_wr_en_o          (mem_b_wr_en_o),
        .mem_b_wr_addr_o        (mem_b_wr_addr_o),
        .mem_b_wr_data_o        (mem_b_wr_data_o),
        .s1_done_o              (s1_done_o),
        .s2_done_o              (s2_done_o),
        .t0_done_o              (t0_done_o),
        .skdecode_done_o        (skdecode_done_o),
        .error_o                (error_o)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // key memory answers every request one cycle later on both lanes
    always @(posedge clk) begin
        rd_valid   <= rd_en;
        rd_data[0] <= key_mem[rd_addr[0]];
        rd_data[1] <= key_mem[rd_addr[1]];
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // unwritten destination words hold values above q, so they never match a coefficient
    function automatic logic [4*COEFF_W-1:0] fill_pattern(input addr_t a);
        return {4{10'h2a5, a}};
    endfunction

    // bits of the key region are counted from the lsb of the first word
    function automatic int key_field(input int src, input int pos, input int width);
        int v;
        int p;
        v = 0;
        for (int b = 0; b < width; b++) begin
            p = pos + b;
            v[b] = key_mem[addr_t'(src + p / REG_W)][5'(p % REG_W)];
        end
        return v;
    endfunction

    // phase 0 is the eta coding of s1 and s2, phase 1 is t0
    function automatic coeff_t skdecode_ref_coeff(input int phase, input int src, input int idx);
        int x;
        if (phase == 0) begin
            x = key_field(src, idx * ETA_W, ETA_W);
            if (x > 2 * ETA) begin
                return '0;
            end
            return coeff_t'((ETA - x + DILITHIUM_Q) % DILITHIUM_Q);
        end
        x = key_field(src, S1S2_WORDS * REG_W + idx * T0_W, T0_W);
        return coeff_t'(((1 << (T0_W - 1)) - x + DILITHIUM_Q) % DILITHIUM_Q);
    endfunction

    // s1s2 codes are drawn in 0 to 4, inject marks one coefficient that gets code 6
    task automatic fill_key(input int src, input int inject);
        logic [ETA_W-1:0] code;
        int p;
        for (int c = 0; c < (S1_POLYS + S2_POLYS) * N_COEFF; c++) begin
            rng  = xorshift32(rng);
            code = ETA_W'(rng % 32'd5);
            if (c == inject) begin
                code = 3'd6;
            end
            for (int b = 0; b < ETA_W; b++) begin
                p = c * ETA_W + b;
                key_mem[addr_t'(src + p / REG_W)][5'(p % REG_W)] = code[b];
            end
        end
        for (int w = 0; w < T0_WORDS; w++) begin
            rng = xorshift32(rng);
            key_mem[addr_t'(src + S1S2_WORDS + w)] = rng;
        end
    endtask

    // ==============================
    // destination compare
    // ==============================
    task automatic compare_dest();
        coeff_t got;
        coeff_t want;
        addr_t  a;
        for (int k = 0; k < S1S2_ADDRS + T0_WR_CYCLES; k++) begin
            a = addr_t'(cur_dst + k);
            for (int lane = 0; lane < 4; lane++) begin
                got = dest_mem[a][lane*COEFF_W +: COEFF_W];
                if (k < S1S2_ADDRS) begin
                    want = skdecode_ref_coeff(0, cur_src, 4 * k + lane);
                end else begin
                    want = skdecode_ref_coeff(1, cur_src, 4 * (k - S1S2_ADDRS) + lane);
                end
                coeff_checks++;
                if (got !== want) begin
                    cmp_errors++;
                    if (cmp_errors <= 20) begin
                        $display("FAIL %0t: addr %0h lane %0d got %0h expected %0h",
                                 $time, a, lane, got, want);
                    end
                end
            end
        end
        // the words just outside the region must not be touched
        a = addr_t'(cur_dst - 1);
        if (dest_mem[a] !== fill_pattern(a)) begin
            cmp_errors++;
            $display("FAIL %0t: write below the destination region at %0h", $time, a);
        end
        a = addr_t'(cur_dst + S1S2_ADDRS + T0_WR_CYCLES);
        if (dest_mem[a] !== fill_pattern(a)) begin
            cmp_errors++;
            $display("FAIL %0t: write above the destination region at %0h", $time, a);
        end
    endtask

    // captures writes, counts them against the done pulses and compares at done
    always @(posedge clk) begin : compare_results
        if (skdecode_enable_i) begin
            a_writes   = 0;
            rd_a_reads = 0;
            s1_pulses  = 0;
            s2_pulses  = 0;
            for (int a = 0; a < (1 << ADDR_W); a++) begin
                dest_mem[addr_t'(a)] = fill_pattern(addr_t'(a));
            end
        end
        if (skdecode_done_o !== t0_done_o) begin
            cmp_errors++;
            $display("FAIL %0t: skdecode_done_o %b differs from t0_done_o %b",
                     $time, skdecode_done_o, t0_done_o);
        end
        if (error_o && !skdecode_done_o) begin
            cmp_errors++;
            $display("FAIL %0t: error_o high outside the done cycle", $time);
        end
        if (s1_done_o) begin
            s1_pulses++;
            if (a_writes != S1_WR_CYCLES) begin
                cmp_errors++;
                $display("FAIL %0t: s1_done_o after %0d writes, expected %0d",
                         $time, a_writes, S1_WR_CYCLES);
            end
        end
        if (s2_done_o) begin
            s2_pulses++;
            if (a_writes != S1S2_WR_CYCLES) begin
                cmp_errors++;
                $display("FAIL %0t: s2_done_o after %0d writes, expected %0d",
                         $time, a_writes, S1S2_WR_CYCLES);
            end
        end
        if (t0_done_o) begin
            if (a_writes != S1S2_WR_CYCLES + T0_WR_CYCLES) begin
                cmp_errors++;
                $display("FAIL %0t: t0_done_o after %0d writes, expected %0d",
                         $time, a_writes, S1S2_WR_CYCLES + T0_WR_CYCLES);
            end
            if (s1_pulses != 1 || s2_pulses != 1) begin
                cmp_errors++;
                $display("FAIL %0t: s1 pulses %0d and s2 pulses %0d, expected one each",
                         $time, s1_pulses, s2_pulses);
            end
            if (error_o !== exp_err) begin
                cmp_errors++;
                $display("FAIL %0t: error_o %b at done, expected %b", $time, error_o, exp_err);
            end
            compare_dest();
            runs_done++;
        end
        // the s1s2 words are read on port a alone
        if (rd_en[1] && rd_a_reads < S1S2_WORDS) begin
            cmp_errors++;
            $display("FAIL %0t: port b read %0h during s1s2", $time, rd_addr[1]);
        end
        if (rd_en[0]) begin
            rd_a_reads++;
        end
        // port b only carries the upper half of an s1s2 chunk
        if (mem_b_wr_en_o && a_writes >= S1S2_WR_CYCLES) begin
            cmp_errors++;
            $display("FAIL %0t: port b wrote %0h during t0", $time, mem_b_wr_addr_o);
        end
        if (mem_a_wr_en_o) begin
            dest_mem[mem_a_wr_addr_o] = mem_a_wr_data_o;
            a_writes++;
        end
        if (mem_b_wr_en_o) begin
            dest_mem[mem_b_wr_addr_o] = mem_b_wr_data_o;
        end
    end

    // ==============================
    // stimulus
    // ==============================
    task automatic start_run(input int src, input int dst, input int inject, input logic err);
        @(posedge clk);
        fill_key(src, inject);
        cur_src = src;
        cur_dst = dst;
        exp_err = err;
        src_base          <= addr_t'(src);
        dest_base         <= addr_t'(dst);
        skdecode_enable_i <= 1'b1;
        @(posedge clk);
        skdecode_enable_i <= 1'b0;
    endtask

    task automatic wait_for_done();
        @(posedge clk);
        while (skdecode_done_o !== 1'b1) begin
            @(posedge clk);
        end
    endtask

    initial begin
        main_errors  = 0;
        cmp_errors   = 0;
        coeff_checks = 0;
        runs_done    = 0;
        reset_n           <= 1'b0;
        zeroize_i         <= 1'b0;
        skdecode_enable_i <= 1'b0;
        src_base          <= '0;
        dest_base         <= '0;
        repeat (4) @(posedge clk);
        reset_n <= 1'b1;
        repeat (2) @(posedge clk);

        // clean run, then one bad eta code, then clean again
        start_run(32'h0100, 32'h0400, -1, 1'b0);
        wait_for_done();
        start_run(32'h0800, 32'h1000, 1234, 1'b1);
        wait_for_done();
        start_run(32'h0100, 32'h0400, -1, 1'b0);
        wait_for_done();

        // zeroize in the middle of the s1s2 writes
        start_run(32'h2000, 32'h2800, -1, 1'b0);
        while (s1_done_o !== 1'b1) begin
            @(posedge clk);
        end
        zeroize_i <= 1'b1;
        @(posedge clk);
        zeroize_i <= 1'b0;
        @(posedge clk);
        if (rd_en !== 2'b00 || mem_a_wr_en_o !== 1'b0 || mem_b_wr_en_o !== 1'b0) begin
            main_errors++;
            $display("FAIL %0t: enables rd %b wr_a %b wr_b %b after zeroize",
                     $time, rd_en, mem_a_wr_en_o, mem_b_wr_en_o);
        end
        if (s2_done_o || t0_done_o || skdecode_done_o || error_o) begin
            main_errors++;
            $display("FAIL %0t: done or error output high after zeroize", $time);
        end
        repeat (3) @(posedge clk);
        start_run(32'h1800, 32'h3000, -1, 1'b0);
        wait_for_done();
        repeat (3) @(posedge clk);

        if (runs_done != N_RUNS - 1) begin
            main_errors++;
            $display("FAIL %0t: %0d runs reached done, expected %0d", $time, runs_done, N_RUNS - 1);
        end
        $display("runs %0d, coefficients checked %0d, errors %0d",
                 runs_done, coeff_checks, main_errors + cmp_errors);
        if (main_errors + cmp_errors == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("timeout: the decoder did not finish all runs within %0d cycles",
                 WATCHDOG_CYCLES);
        $display("CHECKS FAILED");
        $finish;
    end

endmodule

// File: rtl/skdecode_top.sv
// secret-key decoder top, reads packed s1, s2 and t0 from key memory and writes 24-bit coefficients
module skdecode_top
    import skdecode_pkg::*;
(
    input  logic            clk,
    input  logic            reset_n,
    input  logic            zeroize_i,
    input  logic            skdecode_enable_i,
    input  addr_t           keymem_src_base_addr_i,
    input  addr_t           dest_base_addr_i,
    output logic [1:0]      keymem_rd_en_o,
    output addr_t [1:0]     keymem_rd_addr_o,
    input  key_word_t [1:0] keymem_rd_data_i,
    input  logic [1:0]      keymem_rd_valid_i,
    output logic            mem_a_wr_en_o,
    output addr_t           mem_a_wr_addr_o,
    output coeff_t [3:0]    mem_a_wr_data_o,
    output logic            mem_b_wr_en_o,
    output addr_t           mem_b_wr_addr_o,
    output coeff_t [3:0]    mem_b_wr_data_o,
    output logic            s1_done_o,
    output logic            s2_done_o,
    output logic            t0_done_o,
    output logic            skdecode_done_o,
    output logic            error_o
);

    key_word_t [1:0]   rd_data_q;
    logic              rd_valid_q;
    logic [8*ETA_W-1:0] s1s2_chunk;
    logic              s1s2_chunk_valid;
    logic              s1s2_full;
    logic [4*T0_W-1:0] t0_chunk;
    logic              t0_chunk_valid;
    logic              t0_full;
    coeff_t [7:0]      s1s2_coeff;
    logic              s1s2_valid;
    logic              s1s2_error;
    coeff_t [3:0]      t0_coeff;
    logic              t0_valid;
    logic              wr_a_en;
    logic              wr_b_en;
    addr_t             wr_a_addr;
    addr_t             wr_b_addr;
    logic              s1s2_sel;
    logic              t0_sel;
    logic              s1_done;
    logic              s2_done;
    logic              t0_done;
    logic              done;
    logic              error;
    coeff_t [3:0]      wr_a_data;
    coeff_t [3:0]      wr_b_data;

    // ==============================
    // key read data flop
    // ==============================
    // port a valid covers both phases since t0 reads always pair a with b
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            rd_valid_q <= 1'b0;
        end else if (zeroize_i) begin
            rd_valid_q <= 1'b0;
        end else begin
            rd_valid_q <= keymem_rd_valid_i[0];
        end
    end

    always_ff @(posedge clk) begin
        if (zeroize_i) begin
            rd_data_q <= '0;
        end else begin
            if (keymem_rd_valid_i[0]) rd_data_q[0] <= keymem_rd_data_i[0];
            if (keymem_rd_valid_i[1]) rd_data_q[1] <= keymem_rd_data_i[1];
        end
    end

    // s1s2 consumes 32 bits per read and emits 24 bits per write
    skdecode_rd_buffer #(
        .WR_WIDTH (REG_W),
        .RD_WIDTH (8 * ETA_W)
    ) u_s1s2_buffer (
        .clk          (clk),
        .reset_n      (reset_n),
        .zeroize_i    (zeroize_i),
        .data_i       (rd_data_q[0]),
        .data_valid_i (rd_valid_q && s1s2_sel),
        .data_o       (s1s2_chunk),
        .data_valid_o (s1s2_chunk_valid),
        .full_o       (s1s2_full)
    );

    // t0 takes both words, port a supplying the low half
    skdecode_rd_buffer #(
        .WR_WIDTH (2 * REG_W),
        .RD_WIDTH (4 * T0_W)
    ) u_t0_buffer (
        .clk          (clk),
        .reset_n      (reset_n),
        .zeroize_i    (zeroize_i),
        .data_i       (rd_data_q),
        .data_valid_i (rd_valid_q && t0_sel),
        .data_o       (t0_chunk),
        .data_valid_o (t0_chunk_valid),
        .full_o       (t0_full)
    );

    skdecode_s1s2_unpack u_s1s2_unpack (
        .data_i  (s1s2_chunk),
        .valid_i (s1s2_chunk_valid),
        .coeff_o (s1s2_coeff),
        .valid_o (s1s2_valid),
        .error_o (s1s2_error)
    );

    skdecode_t0_unpack u_t0_unpack (
        .clk       (clk),
        .reset_n   (reset_n),
        .zeroize_i (zeroize_i),
        .data_i    (t0_chunk),
        .valid_i   (t0_chunk_valid),
        .coeff_o   (t0_coeff),
        .valid_o   (t0_valid)
    );

    skdecode_ctrl u_ctrl (
        .clk               (clk),
        .reset_n           (reset_n),
        .zeroize_i         (zeroize_i),
        .skdecode_enable_i (skdecode_enable_i),
        .src_base_addr_i   (keymem_src_base_addr_i),
        .dest_base_addr_i  (dest_base_addr_i),
        .s1s2_full_i       (s1s2_full),
        .t0_full_i         (t0_full),
        .s1s2_valid_i      (s1s2_valid),
        .t0_valid_i        (t0_valid),
        .s1s2_error_i      (s1s2_error),
        .keymem_rd_en_o    (keymem_rd_en_o),
        .keymem_rd_addr_o  (keymem_rd_addr_o),
        .wr_a_en_o         (wr_a_en),
        .wr_b_en_o         (wr_b_en),
        .wr_a_addr_o       (wr_a_addr),
        .wr_b_addr_o       (wr_b_addr),
        .s1s2_sel_o        (s1s2_sel),
        .t0_sel_o          (t0_sel),
        .s1_done_o         (s1_done),
        .s2_done_o         (s2_done),
        .t0_done_o         (t0_done),
        .done_o            (done),
        .error_o           (error)
    );

    // ==============================
    // write data mux and output flops
    // ==============================
    always_comb begin
        wr_a_data = s1s2_sel ? s1s2_coeff[3:0] : t0_coeff;
        wr_b_data = s1s2_coeff[7:4];
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            mem_a_wr_en_o   <= 1'b0;
            mem_b_wr_en_o   <= 1'b0;
            s1_done_o       <= 1'b0;
            s2_done_o       <= 1'b0;
            t0_done_o       <= 1'b0;
            skdecode_done_o <= 1'b0;
            error_o         <= 1'b0;
        end else if (zeroize_i) begin
            mem_a_wr_en_o   <= 1'b0;
            mem_b_wr_en_o   <= 1'b0;
            s1_done_o       <= 1'b0;
            s2_done_o       <= 1'b0;
            t0_done_o       <= 1'b0;
            skdecode_done_o <= 1'b0;
            error_o         <= 1'b0;
        end else begin
            mem_a_wr_en_o   <= wr_a_en;
            mem_b_wr_en_o   <= wr_b_en;
            s1_done_o       <= s1_done;
            s2_done_o       <= s2_done;
            t0_done_o       <= t0_done;
            skdecode_done_o <= done;
            error_o         <= error;
        end
    end

    always_ff @(posedge clk) begin
        if (zeroize_i) begin
            mem_a_wr_addr_o <= '0;
            mem_b_wr_addr_o <= '0;
            mem_a_wr_data_o <= '0;
            mem_b_wr_data_o <= '0;
        end else begin
            mem_a_wr_addr_o <= wr_a_addr;
            mem_b_wr_addr_o <= wr_b_addr;
            mem_a_wr_data_o <= wr_a_data;
            mem_b_wr_data_o <= wr_b_data;
        end
    end

endmodule

// File: rtl/skdecode_ctrl.sv
// sequencing FSM of the decoder, issues key reads and destination writes and reports done and error
module skdecode_ctrl
    import skdecode_pkg::*;
(
    input  logic        clk,
    input  logic        reset_n,
    input  logic        zeroize_i,
    input  logic        skdecode_enable_i,
    input  addr_t       src_base_addr_i,
    input  addr_t       dest_base_addr_i,
    input  logic        s1s2_full_i,
    input  logic        t0_full_i,
    input  logic        s1s2_valid_i,
    input  logic        t0_valid_i,
    input  logic        s1s2_error_i,
    output logic [1:0]  keymem_rd_en_o,
    output addr_t [1:0] keymem_rd_addr_o,
    output logic        wr_a_en_o,
    output logic        wr_b_en_o,
    output addr_t       wr_a_addr_o,
    output addr_t       wr_b_addr_o,
    output logic        s1s2_sel_o,
    output logic        t0_sel_o,
    output logic        s1_done_o,
    output logic        s2_done_o,
    output logic        t0_done_o,
    output logic        done_o,
    output logic        error_o
);

    skdec_state_e      state_q;
    addr_t             rd_addr_q;
    addr_t             wr_addr_q;
    logic [ADDR_W-1:0] rd_cnt_q;
    logic [ADDR_W-1:0] wr_cnt_q;
    logic              err_q;
    logic              s1_done_q;
    logic              s2_done_q;

    logic              s1s2_phase;
    logic              t0_phase;
    logic              rd_issue;
    logic              rd_last;
    logic              wr_issue;
    logic              wr_last;
    addr_t             rd_step;
    addr_t             wr_step;

    // ==============================
    // phase decode and issue logic
    // ==============================
    always_comb begin
        s1s2_phase = (state_q == RD_S1S2) || (state_q == WAIT_S1S2);
        t0_phase   = (state_q == RD_T0) || (state_q == WAIT_T0);
        // a read is only issued while the buffer has room for everything in flight
        rd_issue   = ((state_q == RD_S1S2) && !s1s2_full_i) ||
                     ((state_q == RD_T0) && !t0_full_i);
        // t0 reads both ports, so the word count advances by two
        rd_step    = (state_q == RD_T0) ? addr_t'(2) : addr_t'(1);
        rd_last    = (rd_cnt_q + rd_step) ==
                     ((state_q == RD_T0) ? ADDR_W'(T0_WORDS) : ADDR_W'(S1S2_WORDS));
        wr_issue   = (s1s2_phase && s1s2_valid_i) || (t0_phase && t0_valid_i);
        wr_step    = s1s2_phase ? addr_t'(2) : addr_t'(1);
        wr_last    = wr_cnt_q ==
                     (s1s2_phase ? ADDR_W'(S1S2_WR_CYCLES - 1) : ADDR_W'(T0_WR_CYCLES - 1));
    end

    always_comb begin
        keymem_rd_en_o[0]   = rd_issue;
        keymem_rd_en_o[1]   = rd_issue && (state_q == RD_T0);
        keymem_rd_addr_o[0] = rd_addr_q;
        keymem_rd_addr_o[1] = rd_addr_q + addr_t'(1);
        wr_a_en_o           = wr_issue;
        // port b carries the upper four coefficients of an s1s2 chunk
        wr_b_en_o           = s1s2_phase && s1s2_valid_i;
        wr_a_addr_o         = wr_addr_q;
        wr_b_addr_o         = wr_addr_q + addr_t'(1);
        s1s2_sel_o          = s1s2_phase;
        t0_sel_o            = t0_phase;
        s1_done_o           = s1_done_q;
        s2_done_o           = s2_done_q;
        done_o              = (state_q == DONE);
        t0_done_o           = (state_q == DONE);
        error_o             = err_q && (state_q == DONE);
    end

    // ==============================
    // state, counters and error latch
    // ==============================
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            state_q   <= IDLE;
            rd_addr_q <= '0;
            wr_addr_q <= '0;
            rd_cnt_q  <= '0;
            wr_cnt_q  <= '0;
            err_q     <= 1'b0;
            s1_done_q <= 1'b0;
            s2_done_q <= 1'b0;
        end else if (zeroize_i) begin
            state_q   <= IDLE;
            rd_addr_q <= '0;
            wr_addr_q <= '0;
            rd_cnt_q  <= '0;
            wr_cnt_q  <= '0;
            err_q     <= 1'b0;
            s1_done_q <= 1'b0;
            s2_done_q <= 1'b0;
        end else begin
            case (state_q)
                IDLE: begin
                    // base addresses are captured once, the t0 region follows s1s2 directly
                    if (skdecode_enable_i) begin
                        state_q   <= RD_S1S2;
                        rd_addr_q <= src_base_addr_i;
                        wr_addr_q <= dest_base_addr_i;
                        rd_cnt_q  <= '0;
                        wr_cnt_q  <= '0;
                        err_q     <= 1'b0;
                    end
                end
                RD_S1S2:   if (rd_issue && rd_last) state_q <= WAIT_S1S2;
                WAIT_S1S2: if (wr_issue && wr_last) state_q <= RD_T0;
                RD_T0:     if (rd_issue && rd_last) state_q <= WAIT_T0;
                WAIT_T0:   if (wr_issue && wr_last) state_q <= DONE;
                default:   state_q <= IDLE;
            endcase
            if (rd_issue) begin
                rd_addr_q <= rd_addr_q + rd_step;
                rd_cnt_q  <= rd_last ? '0 : rd_cnt_q + rd_step;
            end
            if (wr_issue) begin
                wr_addr_q <= wr_addr_q + wr_step;
                wr_cnt_q  <= wr_last ? '0 : wr_cnt_q + ADDR_W'(1);
            end
            s1_done_q <= wr_issue && s1s2_phase && (wr_cnt_q == ADDR_W'(S1_WR_CYCLES - 1));
            s2_done_q <= wr_issue && s1s2_phase && wr_last;
            // any bad eta code in the run is held until done
            if (s1s2_valid_i && s1s2_error_i) begin
                err_q <= 1'b1;
            end
        end
    end

endmodule

// File: rtl/skdecode_t0_unpack.sv
// registered t0 decoder, four 13-bit fields per chunk mapped into the modulus field
module skdecode_t0_unpack
    import skdecode_pkg::*;
(
    input  logic              clk,
    input  logic              reset_n,
    input  logic              zeroize_i,
    input  logic [4*T0_W-1:0] data_i,
    input  logic              valid_i,
    output coeff_t [3:0]      coeff_o,
    output logic              valid_o
);

    coeff_t [3:0]    coeff_d;
    logic [T0_W-1:0] x;

    always_comb begin
        for (int i = 0; i < 4; i++) begin
            x = data_i[i*T0_W +: T0_W];
            // values above the offset give a negative t0, reduced by adding q
            if (x <= T0_W'(T0_OFFSET)) begin
                coeff_d[i] = coeff_t'(T0_OFFSET) - coeff_t'(x);
            end else begin
                coeff_d[i] = coeff_t'(DILITHIUM_Q + T0_OFFSET) - coeff_t'(x);
            end
        end
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            valid_o <= 1'b0;
        end else if (zeroize_i) begin
            valid_o <= 1'b0;
        end else begin
            valid_o <= valid_i;
        end
    end

    // coefficients are key material and are wiped on zeroize
    always_ff @(posedge clk) begin
        if (zeroize_i) begin
            coeff_o <= '0;
        end else if (valid_i) begin
            coeff_o <= coeff_d;
        end
    end

endmodule

// File: rtl/skdecode_s1s2_unpack.sv
// combinational eta decoder for s1 and s2, eight coefficients per chunk with invalid code detect
module skdecode_s1s2_unpack
    import skdecode_pkg::*;
(
    input  logic [8*ETA_W-1:0] data_i,
    input  logic               valid_i,
    output coeff_t [7:0]       coeff_o,
    output logic               valid_o,
    output logic               error_o
);

    logic [7:0]       bad;
    logic [ETA_W-1:0] code;

    always_comb begin
        for (int i = 0; i < 8; i++) begin
            code   = data_i[i*ETA_W +: ETA_W];
            // only 0 to 2*eta are legal encodings
            bad[i] = code > ETA_W'(2 * ETA);
            if (bad[i]) begin
                coeff_o[i] = '0;
            end else if (code <= ETA_W'(ETA)) begin
                coeff_o[i] = coeff_t'(ETA) - coeff_t'(code);
            end else begin
                // negative results wrap into the upper end of the field
                coeff_o[i] = coeff_t'(DILITHIUM_Q + ETA) - coeff_t'(code);
            end
        end
        valid_o = valid_i;
        error_o = valid_i && (|bad);
    end

endmodule

// File: rtl/skdecode_rd_buffer.sv
// bit accumulator between key reads and an unpacker, instantiated once per polynomial group
module skdecode_rd_buffer #(
    parameter int WR_WIDTH = 32,
    parameter int RD_WIDTH = 24
) (
    input  logic                clk,
    input  logic                reset_n,
    input  logic                zeroize_i,
    input  logic [WR_WIDTH-1:0] data_i,
    input  logic                data_valid_i,
    output logic [RD_WIDTH-1:0] data_o,
    output logic                data_valid_o,
    output logic                full_o
);

    // two words in flight plus one partial chunk always fit
    localparam int DEPTH = 2 * WR_WIDTH + RD_WIDTH;
    localparam int CNT_W = $clog2(DEPTH + 1);

    logic [DEPTH-1:0] buf_q;
    logic [DEPTH-1:0] merged;
    logic [DEPTH-1:0] buf_d;
    logic [CNT_W-1:0] fill_q;
    logic [CNT_W-1:0] merged_fill;
    logic [CNT_W-1:0] fill_d;

    always_comb begin
        merged      = buf_q;
        merged_fill = fill_q;
        // new bits land just above the oldest unread ones
        if (data_valid_i) begin
            merged      = buf_q | (DEPTH'(data_i) << fill_q);
            merged_fill = fill_q + CNT_W'(WR_WIDTH);
        end
        // the incoming word is usable in the cycle it arrives
        data_valid_o = merged_fill >= CNT_W'(RD_WIDTH);
        data_o       = merged[RD_WIDTH-1:0];
        buf_d        = merged;
        fill_d       = merged_fill;
        if (data_valid_o) begin
            buf_d  = merged >> RD_WIDTH;
            fill_d = merged_fill - CNT_W'(RD_WIDTH);
        end
    end

    // full leaves room for the two reads still on their way
    assign full_o = fill_q > CNT_W'(DEPTH - 2 * WR_WIDTH);

    // bits above the fill level must stay zero for the merge to work
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            buf_q  <= '0;
            fill_q <= '0;
        end else if (zeroize_i) begin
            buf_q  <= '0;
            fill_q <= '0;
        end else begin
            buf_q  <= buf_d;
            fill_q <= fill_d;
        end
    end

endmodule

// File: rtl/skdecode_pkg.sv
// shared sizes, types and controller states for the secret-key decoder, imported by every block
package skdecode_pkg;

    // ==============================
    // widths
    // ==============================
    localparam int ADDR_W  = 14;
    localparam int REG_W   = 32;
    localparam int COEFF_W = 24;
    localparam int ETA_W   = 3;
    localparam int T0_W    = 13;

    // ==============================
    // ML-DSA-87 parameters
    // ==============================
    localparam int DILITHIUM_Q = 8380417;
    localparam int ETA         = 2;
    localparam int S1_POLYS    = 7;
    localparam int S2_POLYS    = 8;
    localparam int T0_POLYS    = 8;
    localparam int N_COEFF     = 256;
    // t0 is stored as 2^(d-1) minus the coefficient
    localparam int T0_OFFSET   = 1 << (T0_W - 1);

    // key words per region, bits are packed without gaps
    localparam int S1S2_WORDS = (S1_POLYS + S2_POLYS) * N_COEFF * ETA_W / REG_W;
    localparam int T0_WORDS   = T0_POLYS * N_COEFF * T0_W / REG_W;

    // s1s2 writes carry eight coefficients (two ports), t0 writes carry four
    localparam int S1_WR_CYCLES   = S1_POLYS * N_COEFF / 8;
    localparam int S1S2_WR_CYCLES = (S1_POLYS + S2_POLYS) * N_COEFF / 8;
    localparam int T0_WR_CYCLES   = T0_POLYS * N_COEFF / 4;

    typedef logic [ADDR_W-1:0]  addr_t;
    typedef logic [REG_W-1:0]   key_word_t;
    typedef logic [COEFF_W-1:0] coeff_t;

    // one pass walks through every state in this order
    typedef enum logic [2:0] {
        IDLE,
        RD_S1S2,
        WAIT_S1S2,
        RD_T0,
        WAIT_T0,
        DONE
    } skdec_state_e;

endpackage
